// File: design/wb_pkg.sv
`default_nettype none

package wb_pkg;

    typedef logic [31:0] word_t;        // bus data word
    typedef logic [23:0] flash_addr_t;  // byte address in flash
    typedef logic [3:0]  byte_sel_t;    // one bit per byte lane

    typedef struct packed {
        flash_addr_t adr;
        word_t       dat;
        byte_sel_t   sel;
        logic        we;
        logic        cyc;
    } wb_req_t;

    // configuration register layout
    localparam int CFG_EN_BIT  = 31;
    localparam int CFG_OE_LSB  = 8;
    localparam int CFG_CSB_BIT = 5;
    localparam int CFG_CLK_BIT = 4;
    localparam int CFG_DO_LSB  = 0;

endpackage

`default_nettype wire

// File: design/spi_flash_pkg.sv
`default_nettype none

package spi_flash_pkg;

    typedef logic [7:0] byte_t;
    typedef logic [2:0] xfer_tag_t;     // 0 command, 1..4 data byte in word

    localparam int BYTE_BITS = 8;

    localparam byte_t CMD_RESET_CONT = 8'hFF;  // leave continuous mode
    localparam byte_t CMD_WAKE       = 8'hAB;  // release from power-down
    localparam byte_t CMD_READ       = 8'h03;  // single-bit read

    typedef struct packed {
        logic       csb;
        logic       sck;
        logic [3:0] oe;
        logic [3:0] dout;
    } spi_pins_t;

    typedef enum logic [3:0] {
        RESET_CMD,
        RESET_WAIT,
        WAKE_CMD,
        WAKE_WAIT,
        READ_CMD,
        ADDR_HI,
        ADDR_MID,
        ADDR_LO,
        DATA0,
        DATA1,
        DATA2,
        DATA3
    } seq_state_e;

endpackage

`default_nettype wire

// File: design/spi_byte_shifter.sv
`default_nettype none

module spi_byte_shifter (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     xfer_restart_i,
    input  logic                     din_valid_i,
    input  spi_flash_pkg::byte_t     din_data_i,
    input  spi_flash_pkg::xfer_tag_t din_tag_i,
    input  logic                     din_rd_i,
    input  logic                     miso_i,
    output logic                     din_ready_o,
    output logic                     dout_valid_o,
    output spi_flash_pkg::byte_t     dout_data_o,
    output spi_flash_pkg::xfer_tag_t dout_tag_o,
    output spi_flash_pkg::spi_pins_t pins_o
);

    spi_flash_pkg::byte_t     obuf;
    spi_flash_pkg::byte_t     ibuf;
    logic [3:0]               bit_cnt;     // bits still to sample
    spi_flash_pkg::xfer_tag_t tag_l;
    logic                     rd_l;
    logic                     csb_r;
    logic                     sck_r;

    logic byte_done;
    logic take;

    // last half bit, sck high with every bit sampled
    assign byte_done   = (bit_cnt == 4'd0) && sck_r;
    assign din_ready_o = din_valid_i && (bit_cnt == 4'd0) && !xfer_restart_i;
    assign take        = din_valid_i && din_ready_o;

    assign dout_data_o = ibuf;

    assign pins_o.csb  = csb_r;
    assign pins_o.sck  = sck_r;
    assign pins_o.oe   = {3'b000, !csb_r && !rd_l};  // io0 released in data phase
    assign pins_o.dout = {3'b000, obuf[7]};

    always_ff @(posedge clk) begin
        if (!resetn || xfer_restart_i) begin
            csb_r        <= 1'b1;
            sck_r        <= 1'b0;
            bit_cnt      <= 4'd0;
            tag_l        <= '0;
            rd_l         <= 1'b0;
            dout_valid_o <= 1'b0;
            dout_tag_o   <= '0;
        end else begin
            dout_valid_o <= byte_done;
            if (byte_done)
                dout_tag_o <= tag_l;
            if (bit_cnt != 4'd0 || sck_r) begin
                sck_r <= !sck_r;
                if (sck_r) begin
                    obuf <= {obuf[6:0], 1'b0};         // next bit out on falling sck
                end else begin
                    ibuf    <= {ibuf[6:0], miso_i};    // sample before rising sck
                    bit_cnt <= bit_cnt - 4'd1;
                end
            end
            if (take) begin
                csb_r   <= 1'b0;
                sck_r   <= 1'b0;
                bit_cnt <= 4'(spi_flash_pkg::BYTE_BITS);
                obuf    <= din_data_i;
                tag_l   <= din_tag_i;
                rd_l    <= din_rd_i;
            end
        end
    end

    // a byte in flight keeps the flash selected
    a_take_at_boundary: assert property (
        @(posedge clk) disable iff (!resetn)
        (bit_cnt != 4'd0) |-> (!csb_r && bit_cnt <= 4'(spi_flash_pkg::BYTE_BITS))
    );

endmodule

`default_nettype wire

// File: design/spi_read_seq.sv
`default_nettype none

module spi_read_seq (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     soft_reset_i,
    input  logic                     req_valid_i,
    input  wb_pkg::flash_addr_t      addr_i,
    input  logic                     din_ready_i,
    input  logic                     dout_valid_i,
    input  spi_flash_pkg::byte_t     dout_data_i,
    input  spi_flash_pkg::xfer_tag_t dout_tag_i,
    output logic                     ack_o,
    output wb_pkg::word_t            rdata_o,
    output logic                     din_valid_o,
    output spi_flash_pkg::byte_t     din_data_o,
    output spi_flash_pkg::xfer_tag_t din_tag_o,
    output logic                     din_rd_o,
    output logic                     xfer_restart_o
);

    spi_flash_pkg::seq_state_e state;

    logic [23:0]         buffer;     // first three bytes of the word
    wb_pkg::flash_addr_t rd_addr;
    logic                rd_valid;
    logic                rd_wait;    // prefetched word not yet requested
    logic                rd_inc;

    logic byte_in;
    logic jump;

    assign ack_o   = req_valid_i && (addr_i == rd_addr) && rd_valid;
    assign jump    = req_valid_i && !ack_o && rd_valid && (addr_i != rd_addr + 24'd4);
    assign byte_in = dout_valid_i && !xfer_restart_o;  // drop bytes from a cut stream

    always_ff @(posedge clk) begin
        xfer_restart_o <= 1'b0;
        din_valid_o    <= 1'b0;
        if (!resetn || soft_reset_i) begin
            state          <= spi_flash_pkg::RESET_CMD;
            xfer_restart_o <= 1'b1;
            rd_valid       <= 1'b0;
            rd_wait        <= 1'b0;
            rd_inc         <= 1'b0;
            din_data_o     <= spi_flash_pkg::CMD_RESET_CONT;
            din_tag_o      <= '0;
            din_rd_o       <= 1'b0;
        end else begin
            if (byte_in && dout_tag_i == 3'd1)
                buffer[7:0] <= dout_data_i;
            if (byte_in && dout_tag_i == 3'd2)
                buffer[15:8] <= dout_data_i;
            if (byte_in && dout_tag_i == 3'd3)
                buffer[23:16] <= dout_data_i;
            if (byte_in && dout_tag_i == 3'd4) begin
                rdata_o  <= {dout_data_i, buffer};
                rd_addr  <= rd_inc ? rd_addr + 24'd4 : rd_addr;
                rd_valid <= 1'b1;
                rd_wait  <= rd_inc;
                rd_inc   <= 1'b1;
            end
            if (req_valid_i)
                rd_wait <= 1'b0;

            case (state)
                spi_flash_pkg::RESET_CMD, spi_flash_pkg::WAKE_CMD,
                spi_flash_pkg::READ_CMD: begin
                    din_valid_o <= !din_ready_i;
                    din_tag_o   <= '0;
                    if (state == spi_flash_pkg::RESET_CMD)
                        din_data_o <= spi_flash_pkg::CMD_RESET_CONT;
                    else if (state == spi_flash_pkg::WAKE_CMD)
                        din_data_o <= spi_flash_pkg::CMD_WAKE;
                    else
                        din_data_o <= spi_flash_pkg::CMD_READ;
                    if (din_ready_i)
                        state <= spi_flash_pkg::seq_state_e'(state + 4'd1);
                end
                spi_flash_pkg::RESET_WAIT, spi_flash_pkg::WAKE_WAIT: begin
                    if (byte_in) begin
                        xfer_restart_o <= 1'b1;  // end the one-byte command
                        state <= spi_flash_pkg::seq_state_e'(state + 4'd1);
                    end
                end
                spi_flash_pkg::ADDR_HI: begin
                    if (req_valid_i && !ack_o) begin
                        din_valid_o <= !din_ready_i;
                        din_data_o  <= addr_i[23:16];
                        rd_addr     <= addr_i;
                        if (din_ready_i)
                            state <= spi_flash_pkg::ADDR_MID;
                    end
                end
                spi_flash_pkg::ADDR_MID: begin
                    din_valid_o <= !din_ready_i;
                    din_data_o  <= rd_addr[15:8];
                    if (din_ready_i)
                        state <= spi_flash_pkg::ADDR_LO;
                end
                spi_flash_pkg::ADDR_LO: begin
                    din_valid_o <= !din_ready_i;
                    din_data_o  <= rd_addr[7:0];
                    if (din_ready_i) begin
                        din_data_o <= '0;
                        din_rd_o   <= 1'b1;
                        state      <= spi_flash_pkg::DATA0;
                    end
                end
                spi_flash_pkg::DATA0, spi_flash_pkg::DATA1, spi_flash_pkg::DATA2: begin
                    din_valid_o <= !din_ready_i;
                    din_tag_o   <= 3'(state - spi_flash_pkg::DATA0) + 3'd1;
                    if (din_ready_i)
                        state <= spi_flash_pkg::seq_state_e'(state + 4'd1);
                end
                default: begin
                    // last byte waits until the master wants the buffered word
                    if (!rd_wait || req_valid_i) begin
                        din_valid_o <= !din_ready_i;
                        din_tag_o   <= 3'd4;
                        if (din_ready_i)
                            state <= spi_flash_pkg::DATA0;
                    end
                end
            endcase

            if (jump) begin
                rd_valid       <= 1'b0;
                rd_inc         <= 1'b0;
                din_rd_o       <= 1'b0;
                xfer_restart_o <= 1'b1;
                state          <= spi_flash_pkg::READ_CMD;
            end
        end
    end

    // a buffered word only exists once the wake-up is done
    a_ack_valid: assert property (
        @(posedge clk) disable iff (!resetn)
        rd_valid |-> (state >= spi_flash_pkg::READ_CMD)
    );

    a_tag_range: assert property (
        @(posedge clk) disable iff (!resetn)
        din_valid_o |-> (din_tag_o <= 3'd4)
    );

endmodule

`default_nettype wire

// File: design/spi_bitbang_cfg.sv
`default_nettype none

module spi_bitbang_cfg (
    input  logic                     clk,
    input  logic                     resetn,
    input  wb_pkg::wb_req_t          wb_i,
    input  logic                     cfg_stb_i,
    input  spi_flash_pkg::spi_pins_t engine_pins_i,
    input  logic [3:0]               io_di_i,
    output logic                     cfg_ack_o,
    output wb_pkg::word_t            cfg_dat_o,
    output logic                     soft_reset_o,
    output spi_flash_pkg::spi_pins_t flash_pins_o,
    output logic [3:0]               io_oeb_o
);

    logic             cfg_en;
    logic             cfg_csb;
    logic             cfg_clk;
    logic [3:0]       cfg_oe;
    logic [3:0]       cfg_do;
    wb_pkg::byte_sel_t cfg_we;

    assign cfg_ack_o = wb_i.cyc && cfg_stb_i;  // zero wait states
    assign cfg_we    = (cfg_ack_o && wb_i.we) ? wb_i.sel : '0;

    always_ff @(posedge clk) begin
        soft_reset_o <= !cfg_en || (|cfg_we);
        if (!resetn) begin
            soft_reset_o <= 1'b1;
            cfg_en       <= 1'b1;
            cfg_csb      <= 1'b1;
            cfg_clk      <= 1'b0;
            cfg_oe       <= '0;
            cfg_do       <= '0;
        end else begin
            if (cfg_we[0]) begin
                cfg_csb <= wb_i.dat[wb_pkg::CFG_CSB_BIT];
                cfg_clk <= wb_i.dat[wb_pkg::CFG_CLK_BIT];
                cfg_do  <= wb_i.dat[wb_pkg::CFG_DO_LSB +: 4];
            end
            if (cfg_we[1])
                cfg_oe <= wb_i.dat[wb_pkg::CFG_OE_LSB +: 4];
            if (cfg_we[3])
                cfg_en <= wb_i.dat[wb_pkg::CFG_EN_BIT];
        end
    end

    assign flash_pins_o = cfg_en ? engine_pins_i : {cfg_csb, cfg_clk, cfg_oe, cfg_do};
    assign io_oeb_o     = !resetn ? 4'hF : ~flash_pins_o.oe;

    // readback shows the live pins
    always_comb begin
        cfg_dat_o = '0;
        cfg_dat_o[wb_pkg::CFG_EN_BIT]       = cfg_en;
        cfg_dat_o[wb_pkg::CFG_OE_LSB +: 4]  = ~io_oeb_o;
        cfg_dat_o[wb_pkg::CFG_CSB_BIT]      = flash_pins_o.csb;
        cfg_dat_o[wb_pkg::CFG_CLK_BIT]      = flash_pins_o.sck;
        cfg_dat_o[wb_pkg::CFG_DO_LSB +: 4]  = io_di_i;
    end

endmodule

`default_nettype wire

// File: design/spi_flash_top.sv
`default_nettype none

module spi_flash_top (
    input  logic            clk,
    input  logic            resetn,
    input  wb_pkg::wb_req_t wb_i,
    input  logic            flash_stb_i,
    input  logic            cfg_stb_i,
    output logic            flash_ack_o,
    output logic            cfg_ack_o,
    output wb_pkg::word_t   flash_dat_o,
    output wb_pkg::word_t   cfg_dat_o,
    output logic            flash_csb_o,
    output logic            flash_clk_o,
    output logic [3:0]      flash_io_oeb_o,
    output logic [3:0]      flash_io_do_o,
    input  logic [3:0]      flash_io_di_i
);

    logic                     req_valid;
    logic                     soft_reset;
    logic                     din_valid;
    logic                     din_ready;
    spi_flash_pkg::byte_t     din_data;
    spi_flash_pkg::xfer_tag_t din_tag;
    logic                     din_rd;
    logic                     dout_valid;
    spi_flash_pkg::byte_t     dout_data;
    spi_flash_pkg::xfer_tag_t dout_tag;
    logic                     xfer_restart;
    spi_flash_pkg::spi_pins_t engine_pins;
    spi_flash_pkg::spi_pins_t flash_pins;

    assign req_valid     = wb_i.cyc && flash_stb_i;
    assign flash_csb_o   = flash_pins.csb;
    assign flash_clk_o   = flash_pins.sck;
    assign flash_io_do_o = flash_pins.dout;

    spi_read_seq u_seq (
        .clk            (clk),
        .resetn         (resetn),
        .soft_reset_i   (soft_reset),
        .req_valid_i    (req_valid),
        .addr_i         (wb_i.adr),
        .din_ready_i    (din_ready),
        .dout_valid_i   (dout_valid),
        .dout_data_i    (dout_data),
        .dout_tag_i     (dout_tag),
        .ack_o          (flash_ack_o),
        .rdata_o        (flash_dat_o),
        .din_valid_o    (din_valid),
        .din_data_o     (din_data),
        .din_tag_o      (din_tag),
        .din_rd_o       (din_rd),
        .xfer_restart_o (xfer_restart)
    );

    spi_byte_shifter u_shift (
        .clk            (clk),
        .resetn         (resetn),
        .xfer_restart_i (xfer_restart),
        .din_valid_i    (din_valid),
        .din_data_i     (din_data),
        .din_tag_i      (din_tag),
        .din_rd_i       (din_rd),
        .miso_i         (flash_io_di_i[1]),  // io1 carries read data
        .din_ready_o    (din_ready),
        .dout_valid_o   (dout_valid),
        .dout_data_o    (dout_data),
        .dout_tag_o     (dout_tag),
        .pins_o         (engine_pins)
    );

    spi_bitbang_cfg u_cfg (
        .clk            (clk),
        .resetn         (resetn),
        .wb_i           (wb_i),
        .cfg_stb_i      (cfg_stb_i),
        .engine_pins_i  (engine_pins),
        .io_di_i        (flash_io_di_i),
        .cfg_ack_o      (cfg_ack_o),
        .cfg_dat_o      (cfg_dat_o),
        .soft_reset_o   (soft_reset),
        .flash_pins_o   (flash_pins),
        .io_oeb_o       (flash_io_oeb_o)
    );

endmodule

`default_nettype wire

// File: tb/flash_model.sv
`default_nettype none

module flash_model (
    input  logic csb_i,
    input  logic sck_i,
    input  logic io0_i,
    output logic io1_o
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [7:0]  cmd        = 8'h00;
    logic [7:0]  in_sr      = 8'h00;
    logic [7:0]  out_sr     = 8'h00;
    logic [23:0] addr       = 24'h0;
    logic        data_phase = 1'b0;
    logic        io1        = 1'b0;
    int          bits_in    = 0;
    int          bits_out   = 0;
    int          byte_cnt   = 0;

    assign io1_o = io1;

    // flash content, same rule as the testbench reference
    function automatic logic [7:0] content_at(input logic [23:0] a);
        return a[7:0] ^ a[15:8] ^ 8'h5A;
    endfunction

    always @(posedge csb_i or posedge sck_i or negedge sck_i) begin
        if (csb_i !== 1'b0) begin   // deselected, io1 parked low
            bits_in    = 0;
            bits_out   = 0;
            byte_cnt   = 0;
            data_phase = 1'b0;
            io1       <= 1'b0;
        end else if (sck_i) begin
            if (!data_phase) begin
                in_sr = {in_sr[6:0], io0_i};
                bits_in++;
                if (bits_in == 8) begin
                    bits_in = 0;
                    if (byte_cnt == 0)
                        cmd = in_sr;
                    else
                        addr = {addr[15:0], in_sr};
                    if (cmd == 8'h03 && byte_cnt == 3)
                        data_phase = 1'b1;
                    byte_cnt++;
                end
            end
        end else if (data_phase) begin
            if (bits_out == 0) begin
                out_sr   = content_at(addr);
                addr     = addr + 24'd1;
                bits_out = 8;
            end
            io1     <= out_sr[7];   // msb first
            out_sr   = {out_sr[6:0], 1'b0};
            bits_out--;
        end
    end

endmodule

`default_nettype wire

// File: tb/tb_top.sv
`default_nettype none

module tb_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int WATCHDOG_CYCLES = 400 * 80 + 400;  // words plus wake-up

    logic            clk = 1'b0;
    logic            resetn;
    wb_pkg::wb_req_t wb;
    logic            flash_stb;
    logic            cfg_stb;
    logic            flash_ack;
    logic            cfg_ack;
    wb_pkg::word_t   flash_dat;
    wb_pkg::word_t   cfg_dat;
    logic            flash_csb;
    logic            flash_clk;
    logic [3:0]      flash_io_oeb;
    logic [3:0]      flash_io_do;
    logic [3:0]      flash_io_di;
    logic            model_io1;
    logic            drive_pins;     // tb owns every io input in bit-bang mode
    logic [3:0]      pin_levels;

    int            seed;
    int            chk_errors    = 0;
    int            cmp_errors    = 0;
    int            reads_issued  = 0;
    int            reads_checked = 0;
    wb_pkg::word_t exp_word;

    always #10 clk = ~clk;

    assign flash_io_di = drive_pins ? pin_levels : {2'b00, model_io1, 1'b0};

    spi_flash_top u_dut (
        .clk            (clk),
        .resetn         (resetn),
        .wb_i           (wb),
        .flash_stb_i    (flash_stb),
        .cfg_stb_i      (cfg_stb),
        .flash_ack_o    (flash_ack),
        .cfg_ack_o      (cfg_ack),
        .flash_dat_o    (flash_dat),
        .cfg_dat_o      (cfg_dat),
        .flash_csb_o    (flash_csb),
        .flash_clk_o    (flash_clk),
        .flash_io_oeb_o (flash_io_oeb),
        .flash_io_do_o  (flash_io_do),
        .flash_io_di_i  (flash_io_di)
    );

    flash_model u_flash (
        .csb_i (flash_csb),
        .sck_i (flash_clk),
        .io0_i (flash_io_do[0]),
        .io1_o (model_io1)
    );

    function automatic spi_flash_pkg::byte_t byte_at(input wb_pkg::flash_addr_t a);
        return a[7:0] ^ a[15:8] ^ 8'h5A;
    endfunction

    // lowest address lands in bits 7..0
    function automatic wb_pkg::word_t ref_word(input wb_pkg::flash_addr_t a);
        return {byte_at(a + 24'd3), byte_at(a + 24'd2), byte_at(a + 24'd1), byte_at(a)};
    endfunction

    task automatic check_eq(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail %s got 0x%0h expected 0x%0h", name, got, exp);
            chk_errors++;
        end
    endtask

    task automatic check_reset_state();
        check_eq("flash_csb_o", 32'(flash_csb), 32'd1);
        check_eq("flash_io_oeb_o", {28'h0, flash_io_oeb}, 32'hF);
        check_eq("flash_ack_o", 32'(flash_ack), 32'd0);
        check_eq("cfg_dat_o[31]", 32'(cfg_dat[wb_pkg::CFG_EN_BIT]), 32'd1);
    endtask

    task automatic read_word(input wb_pkg::flash_addr_t addr);
        wb_pkg::wb_req_t req;
        req     = '0;
        req.adr = addr;
        req.sel = 4'hF;
        req.cyc = 1'b1;
        @(posedge clk);
        wb        <= req;
        flash_stb <= 1'b1;
        do
            @(negedge clk);
        while (!flash_ack);
        @(posedge clk);
        wb        <= '0;
        flash_stb <= 1'b0;
        reads_issued++;
    endtask

    task automatic write_cfg(input wb_pkg::word_t data, input wb_pkg::byte_sel_t sel);
        wb_pkg::wb_req_t req;
        req     = '0;
        req.dat = data;
        req.sel = sel;
        req.we  = 1'b1;
        req.cyc = 1'b1;
        @(posedge clk);
        wb      <= req;
        cfg_stb <= 1'b1;
        @(posedge clk);   // register takes the write here
        wb      <= '0;
        cfg_stb <= 1'b0;
    endtask

    task automatic read_cfg(output wb_pkg::word_t data);
        wb_pkg::wb_req_t req;
        req     = '0;
        req.sel = 4'hF;
        req.cyc = 1'b1;
        @(posedge clk);
        wb      <= req;
        cfg_stb <= 1'b1;
        @(negedge clk);
        check_eq("cfg_ack_o", 32'(cfg_ack), 32'd1);
        data = cfg_dat;
        @(posedge clk);
        wb      <= '0;
        cfg_stb <= 1'b0;
    endtask

    // every acknowledged read against the reference
    always @(negedge clk) begin
        if (resetn && flash_ack) begin
            exp_word = ref_word(wb.adr);
            if (flash_dat !== exp_word) begin
                $display("Fail flash_dat_o got 0x%h expected 0x%h at address 0x%h",
                         flash_dat, exp_word, wb.adr);
                cmp_errors++;
            end
            reads_checked++;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("run timed out after %0d cycles without finishing the tests",
                 WATCHDOG_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        wb_pkg::word_t       rnd;
        wb_pkg::word_t       word;
        wb_pkg::word_t       exp_cfg;
        wb_pkg::word_t       got;
        wb_pkg::flash_addr_t base;
        logic                csb;
        logic                sck;
        seed        = 32'h4f33_6a91;
        resetn     <= 1'b0;
        wb         <= '0;
        flash_stb  <= 1'b0;
        cfg_stb    <= 1'b0;
        drive_pins <= 1'b0;
        pin_levels <= 4'h0;

        repeat (5) @(posedge clk);
        @(negedge clk);
        check_reset_state();
        repeat (5) @(posedge clk);
        resetn <= 1'b1;
        @(posedge clk);
        @(negedge clk);
        check_reset_state();

        for (int i = 0; i < 100; i++) begin
            rnd = $random(seed);
            read_word(rnd[23:0] & 24'hFF_FFFC);
        end

        for (int r = 0; r < 5; r++) begin
            rnd  = $random(seed);
            base = rnd[23:0] & 24'hFF_FFFC;
            for (int j = 0; j < 20; j++)
                read_word(base + 24'(4 * j));
        end

        for (int i = 0; i < 6; i++) begin
            rnd  = $random(seed);
            csb  = (i == 5) ? 1'b1 : rnd[0];   // leave the flash deselected
            sck  = (i == 5) ? 1'b0 : rnd[1];
            word = '0;
            word[wb_pkg::CFG_CSB_BIT]     = csb;
            word[wb_pkg::CFG_CLK_BIT]     = sck;
            word[wb_pkg::CFG_OE_LSB +: 4] = rnd[7:4];
            word[wb_pkg::CFG_DO_LSB +: 4] = rnd[11:8];
            drive_pins <= 1'b1;
            pin_levels <= rnd[15:12];
            write_cfg(word, 4'hF);
            @(negedge clk);
            check_eq("flash_csb_o", 32'(flash_csb), 32'(csb));
            check_eq("flash_clk_o", 32'(flash_clk), 32'(sck));
            check_eq("flash_io_do_o", {28'h0, flash_io_do}, {28'h0, rnd[11:8]});
            check_eq("flash_io_oeb_o", {28'h0, flash_io_oeb}, {28'h0, ~rnd[7:4]});
            exp_cfg = word;
            exp_cfg[wb_pkg::CFG_DO_LSB +: 4] = rnd[15:12];   // readback shows inputs
            read_cfg(got);
            check_eq("cfg_dat_o", got, exp_cfg);
        end

        drive_pins <= 1'b0;
        write_cfg(32'h8000_0000, 4'b1000);
        @(negedge clk);
        check_eq("cfg_dat_o[31]", 32'(cfg_dat[wb_pkg::CFG_EN_BIT]), 32'd1);
        for (int i = 0; i < 20; i++) begin
            rnd = $random(seed);
            read_word(rnd[23:0] & 24'hFF_FFFC);
        end

        repeat (4) @(posedge clk);
        if (reads_checked != reads_issued) begin
            $display("acknowledge count wrong: %0d reads issued but %0d acknowledges seen",
                     reads_issued, reads_checked);
            chk_errors++;
        end
        $display("summary: %0d reads, %0d check errors, %0d data errors",
                 reads_issued, chk_errors, cmp_errors);
        if (chk_errors + cmp_errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
design/wb_pkg.sv
design/spi_flash_pkg.sv
design/spi_byte_shifter.sv
design/spi_read_seq.sv
design/spi_bitbang_cfg.sv
design/spi_flash_top.sv
tb/flash_model.sv
tb/tb_top.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_top -f build.f -o tb_sim

./obj_dir/tb_sim > sim.log 2>&1
cat sim.log

if grep -q "TEST FAIL" sim.log; then
    exit 1
fi
